/* design/tspp_pkg.sv */
package tspp_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [6:0]  opcode_t;

  // Core constants
  localparam word_t RESET_PC   = 32'h0;
  localparam word_t HALT_INSTR = 32'hFFFF_FFFF;

  // Data RAM geometry and pacing
  localparam int DMEM_LATENCY = 2;
  localparam int DMEM_WORDS   = 256;
  localparam int DMEM_AW      = $clog2(DMEM_WORDS);
  localparam int DMEM_CNT_W   = $clog2(DMEM_LATENCY + 1);

  typedef logic [DMEM_CNT_W-1:0] dmem_cnt_t;

  // The access cycle itself is the first busy cycle
  localparam dmem_cnt_t DMEM_RELOAD = dmem_cnt_t'(DMEM_LATENCY - 1);

  // RV32I major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // Encoded as funct3, stores use the same values
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_type_t;

  typedef enum logic [1:0] {RUN, MEM_WAIT, HALTED} hazard_state_t;

  typedef struct packed {
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  valid;
  } fetch_ex_t;

  typedef struct packed {
    logic     ren;
    logic     wen;
    word_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } dbus_req_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     wdata;
    logic      mal;
  } retire_t;

endpackage

/* design/tspp_fetch_stage.sv */
module tspp_fetch_stage (
  input  logic                CLK,
  input  logic                reset,
  input  logic                stall,
  input  logic                flush,
  input  logic                brj_taken,
  input  tspp_pkg::word_t     brj_addr,
  input  tspp_pkg::word_t     imem_rdata,
  output tspp_pkg::word_t     imem_addr,
  output tspp_pkg::fetch_ex_t fetch_ex
);

  tspp_pkg::word_t pc_q;
  tspp_pkg::word_t pc_seq;

  // Instruction memory answers in the same cycle
  assign imem_addr = pc_q;
  assign pc_seq    = pc_q + 32'd4;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc_q           <= tspp_pkg::RESET_PC;
      fetch_ex.valid <= 1'b0;
    end else if (!stall) begin
      // Redirect wins over the sequential PC
      pc_q           <= brj_taken ? brj_addr : pc_seq;
      // Wrong-path fetch becomes a bubble
      fetch_ex.valid <= ~flush;
    end
    // Payload follows the valid bit
    if (!stall) begin
      fetch_ex.pc    <= pc_q;
      fetch_ex.pc4   <= pc_seq;
      fetch_ex.instr <= imem_rdata;
    end
  end

endmodule

/* design/tspp_execute_stage.sv */
module tspp_execute_stage (
  input  logic                 CLK,
  input  logic                 reset,
  input  tspp_pkg::fetch_ex_t  fetch_ex,
  input  logic                 stall,
  input  tspp_pkg::word_t      rs1_data,
  input  tspp_pkg::word_t      rs2_data,
  input  tspp_pkg::word_t      dmem_rdata,
  output tspp_pkg::reg_addr_t  rs1_sel,
  output tspp_pkg::reg_addr_t  rs2_sel,
  output tspp_pkg::reg_addr_t  rd_sel,
  output logic                 rf_wen,
  output tspp_pkg::word_t      rf_wdata,
  output tspp_pkg::dbus_req_t  dbus,
  output logic                 brj_taken,
  output tspp_pkg::word_t      brj_addr,
  output logic                 mem_access,
  output logic                 halt_seen,
  output tspp_pkg::retire_t    retire
);

  tspp_pkg::word_t      instr;
  tspp_pkg::word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  tspp_pkg::word_t      alu_a, alu_b, alu_out;
  tspp_pkg::word_t      jalr_sum, store_data, byte_shifted, load_ext;
  tspp_pkg::alu_op_t    arith_op, alu_op;
  tspp_pkg::load_type_t mem_type;
  tspp_pkg::byte_en_t   byte_en;
  logic [2:0]           funct3;
  logic [1:0]           byte_offset;
  logic                 is_load, is_store, is_branch, is_jal, is_jalr, dec_wen;
  logic                 br_cond, misaligned, mal_addr, wb;

  assign instr   = fetch_ex.instr;
  assign funct3  = instr[14:12];
  assign rs1_sel = instr[19:15];
  assign rs2_sel = instr[24:20];
  assign rd_sel  = instr[11:7];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // OP and OP-IMM share funct3, bit 5 marks the register form that may SUB
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (instr[5] && instr[30]) ? tspp_pkg::ALU_SUB : tspp_pkg::ALU_ADD;
      3'b001:  arith_op = tspp_pkg::ALU_SLL;
      3'b010:  arith_op = tspp_pkg::ALU_SLT;
      3'b011:  arith_op = tspp_pkg::ALU_SLTU;
      3'b100:  arith_op = tspp_pkg::ALU_XOR;
      3'b101:  arith_op = instr[30] ? tspp_pkg::ALU_SRA : tspp_pkg::ALU_SRL;
      3'b110:  arith_op = tspp_pkg::ALU_OR;
      default: arith_op = tspp_pkg::ALU_AND;
    endcase
  end

  // Main decode, defaults to a register-register add with no side effects
  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    dec_wen   = 1'b0;
    alu_a     = rs1_data;
    alu_b     = rs2_data;
    alu_op    = tspp_pkg::ALU_ADD;
    case (instr[6:0])
      tspp_pkg::OPC_LUI: begin
        alu_a   = '0;
        alu_b   = imm_u;
        dec_wen = 1'b1;
      end
      tspp_pkg::OPC_AUIPC: begin
        alu_a   = fetch_ex.pc;
        alu_b   = imm_u;
        dec_wen = 1'b1;
      end
      tspp_pkg::OPC_JAL: begin
        is_jal  = 1'b1;
        dec_wen = 1'b1;
      end
      tspp_pkg::OPC_JALR: begin
        is_jalr = 1'b1;
        dec_wen = 1'b1;
      end
      tspp_pkg::OPC_BRANCH: is_branch = 1'b1;
      tspp_pkg::OPC_LOAD: begin
        is_load = 1'b1;
        alu_b   = imm_i;
        dec_wen = 1'b1;
      end
      tspp_pkg::OPC_STORE: begin
        is_store = 1'b1;
        alu_b    = imm_s;
      end
      tspp_pkg::OPC_OP_IMM: begin
        alu_b   = imm_i;
        alu_op  = arith_op;
        dec_wen = 1'b1;
      end
      tspp_pkg::OPC_OP: begin
        alu_op  = arith_op;
        dec_wen = 1'b1;
      end
      // Halt word and unknown opcodes do nothing here
      default: ;
    endcase
  end

  // ALU, shift amount from the low five bits
  always_comb begin
    case (alu_op)
      tspp_pkg::ALU_SUB:  alu_out = alu_a - alu_b;
      tspp_pkg::ALU_SLL:  alu_out = alu_a << alu_b[4:0];
      tspp_pkg::ALU_SLT:  alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
      tspp_pkg::ALU_SLTU: alu_out = {31'b0, alu_a < alu_b};
      tspp_pkg::ALU_XOR:  alu_out = alu_a ^ alu_b;
      tspp_pkg::ALU_SRL:  alu_out = alu_a >> alu_b[4:0];
      tspp_pkg::ALU_SRA:  alu_out = $signed(alu_a) >>> alu_b[4:0];
      tspp_pkg::ALU_OR:   alu_out = alu_a | alu_b;
      tspp_pkg::ALU_AND:  alu_out = alu_a & alu_b;
      default:            alu_out = alu_a + alu_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  br_cond = (rs1_data == rs2_data);
      3'b001:  br_cond = (rs1_data != rs2_data);
      3'b100:  br_cond = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  br_cond = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  br_cond = (rs1_data < rs2_data);
      3'b111:  br_cond = (rs1_data >= rs2_data);
      default: br_cond = 1'b0;
    endcase
  end

  // Static not-taken, so any taken branch or jump redirects
  assign jalr_sum  = rs1_data + imm_i;
  assign brj_taken = fetch_ex.valid & (is_jal | is_jalr | (is_branch & br_cond));
  assign brj_addr  = is_jalr ? {jalr_sum[31:1], 1'b0}
                             : fetch_ex.pc + (is_jal ? imm_j : imm_b);

  assign mem_type    = tspp_pkg::load_type_t'(funct3);
  assign byte_offset = alu_out[1:0];

  // Lane enables, replicated store data and alignment per access size
  always_comb begin
    case (mem_type)
      tspp_pkg::LB, tspp_pkg::LBU: begin
        byte_en    = 4'b0001 << byte_offset;
        store_data = {4{rs2_data[7:0]}};
        misaligned = 1'b0;
      end
      tspp_pkg::LH, tspp_pkg::LHU: begin
        byte_en    = byte_offset[1] ? 4'b1100 : 4'b0011;
        store_data = {2{rs2_data[15:0]}};
        misaligned = byte_offset[0];
      end
      tspp_pkg::LW: begin
        byte_en    = 4'b1111;
        store_data = rs2_data;
        misaligned = (byte_offset != 2'b00);
      end
      default: begin
        byte_en    = 4'b0000;
        store_data = rs2_data;
        misaligned = 1'b0;
      end
    endcase
  end

  assign mal_addr = fetch_ex.valid & (is_load | is_store) & misaligned;

  // Misaligned accesses never reach the RAM
  assign dbus = '{
    ren:     fetch_ex.valid & is_load & ~misaligned,
    wen:     fetch_ex.valid & is_store & ~misaligned,
    addr:    alu_out,
    wdata:   store_data,
    byte_en: byte_en
  };
  assign mem_access = dbus.ren | dbus.wen;
  assign halt_seen  = fetch_ex.valid & (instr == tspp_pkg::HALT_INSTR);

  // Move the addressed lane down to bit 0, then extend
  assign byte_shifted = dmem_rdata >> {byte_offset, 3'b000};
  always_comb begin
    case (mem_type)
      tspp_pkg::LB:  load_ext = {{24{byte_shifted[7]}}, byte_shifted[7:0]};
      tspp_pkg::LBU: load_ext = {24'b0, byte_shifted[7:0]};
      tspp_pkg::LH:  load_ext = {{16{byte_shifted[15]}}, byte_shifted[15:0]};
      tspp_pkg::LHU: load_ext = {16'b0, byte_shifted[15:0]};
      default:       load_ext = dmem_rdata;
    endcase
  end

  // Writeback source, jumps link pc4
  always_comb begin
    if (is_load) begin
      rf_wdata = load_ext;
    end else if (is_jal || is_jalr) begin
      rf_wdata = fetch_ex.pc4;
    end else begin
      rf_wdata = alu_out;
    end
  end

  // Stall drops in the last wait cycle, which is when a load completes
  assign rf_wen = fetch_ex.valid & dec_wen & ~stall & ~mal_addr;
  assign wb     = rf_wen & (rd_sel != '0);

  // Retire trace, rd and data read zero when nothing is written
  always_ff @(posedge CLK) begin
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= fetch_ex.valid & ~stall;
    end
    if (fetch_ex.valid && !stall) begin
      retire.pc    <= fetch_ex.pc;
      retire.rd    <= wb ? rd_sel : '0;
      retire.wdata <= wb ? rf_wdata : '0;
      retire.mal   <= mal_addr;
    end
  end

endmodule

/* design/rv32i_reg_file.sv */
module rv32i_reg_file (
  input  logic                CLK,
  input  logic                reset,
  input  tspp_pkg::reg_addr_t rs1_sel,
  input  tspp_pkg::reg_addr_t rs2_sel,
  input  tspp_pkg::reg_addr_t rd_sel,
  input  logic                wen,
  input  tspp_pkg::word_t     wdata,
  output tspp_pkg::word_t     rs1_data,
  output tspp_pkg::word_t     rs2_data
);

  tspp_pkg::word_t regs [32];

  // x0 is cleared by reset and never written, so it reads zero
  always_ff @(posedge CLK) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wen && (rd_sel != '0)) begin
      regs[rd_sel] <= wdata;
    end
  end

  // Two asynchronous read ports
  assign rs1_data = regs[rs1_sel];
  assign rs2_data = regs[rs2_sel];

endmodule

/* design/tspp_hazard_fsm.sv */
module tspp_hazard_fsm (
  input  logic CLK,
  input  logic reset,
  input  logic mem_access,
  input  logic busy,
  input  logic brj_taken,
  input  logic halt_seen,
  output logic stall,
  output logic flush,
  output logic halt
);

  tspp_pkg::hazard_state_t state_q, state_d;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state_q <= tspp_pkg::RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // HALTED is final
  always_comb begin
    state_d = state_q;
    case (state_q)
      tspp_pkg::RUN: begin
        if (halt_seen) begin
          state_d = tspp_pkg::HALTED;
        end else if (mem_access) begin
          state_d = tspp_pkg::MEM_WAIT;
        end
      end
      tspp_pkg::MEM_WAIT: begin
        if (halt_seen) begin
          state_d = tspp_pkg::HALTED;
        end else if (!busy) begin
          state_d = tspp_pkg::RUN;
        end
      end
      default: state_d = tspp_pkg::HALTED;
    endcase
  end

  // Hold the access cycle and the wait; the last wait cycle lets the access retire
  // Halt word also holds so it stays in execute
  assign stall = (state_q == tspp_pkg::HALTED)
               | ((state_q == tspp_pkg::RUN) & (mem_access | halt_seen))
               | ((state_q == tspp_pkg::MEM_WAIT) & busy);
  assign flush = (state_q == tspp_pkg::RUN) & brj_taken;
  assign halt  = (state_q == tspp_pkg::HALTED);

endmodule

/* design/dmem_latency_timer.sv */
module dmem_latency_timer (
  input  logic CLK,
  input  logic reset,
  input  logic start,
  output logic busy
);

  tspp_pkg::dmem_cnt_t count_q;

  // Load on the access cycle, then count down to zero
  always_ff @(posedge CLK) begin
    if (reset) begin
      count_q <= '0;
    end else if (start) begin
      count_q <= tspp_pkg::DMEM_RELOAD;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Access cycle plus the remaining count gives DMEM_LATENCY busy cycles
  assign busy = start | (count_q != '0);

endmodule

/* design/data_ram.sv */
module data_ram (
  input  logic                CLK,
  input  logic                reset,
  input  tspp_pkg::dbus_req_t dbus,
  output tspp_pkg::word_t     rdata,
  output logic                busy
);

  tspp_pkg::word_t                mem [tspp_pkg::DMEM_WORDS];
  logic [tspp_pkg::DMEM_AW-1:0]   idx;
  logic                           active_q;
  logic                           start;

  // Word index, byte offset bits are handled by the lane enables
  assign idx = dbus.addr[tspp_pkg::DMEM_AW+1:2];

  // Request stays up until retire, only its first cycle starts an access
  assign start = (dbus.ren | dbus.wen) & ~active_q;

  dmem_latency_timer dmem_latency_timer_inst (
    .CLK   (CLK),
    .reset (reset),
    .start (start),
    .busy  (busy)
  );

  // Access is open from start until the wait is over
  always_ff @(posedge CLK) begin
    if (reset) begin
      active_q <= 1'b0;
    end else if (start) begin
      active_q <= 1'b1;
    end else if (!busy) begin
      active_q <= 1'b0;
    end
  end

  // Write enabled lanes, capture read data once per access
  always_ff @(posedge CLK) begin
    if (start && dbus.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (dbus.byte_en[i]) begin
          mem[idx][8*i +: 8] <= dbus.wdata[8*i +: 8];
        end
      end
    end
    if (start && dbus.ren) begin
      rdata <= mem[idx];
    end
  end

endmodule

/* design/tspp_top.sv */
module tspp_top (
  input  logic              CLK,
  input  logic              reset,
  input  tspp_pkg::word_t   imem_rdata,
  output tspp_pkg::word_t   imem_addr,
  output tspp_pkg::retire_t retire,
  output logic              halt
);

  tspp_pkg::fetch_ex_t fetch_ex;
  tspp_pkg::dbus_req_t dbus;
  tspp_pkg::word_t     brj_addr, dmem_rdata, rs1_data, rs2_data, rf_wdata;
  tspp_pkg::reg_addr_t rs1_sel, rs2_sel, rd_sel;
  logic                stall, flush, brj_taken, busy, mem_access, halt_seen, rf_wen;

  tspp_fetch_stage tspp_fetch_stage_inst (
    .CLK        (CLK),
    .reset      (reset),
    .stall      (stall),
    .flush      (flush),
    .brj_taken  (brj_taken),
    .brj_addr   (brj_addr),
    .imem_rdata (imem_rdata),
    .imem_addr  (imem_addr),
    .fetch_ex   (fetch_ex)
  );

  tspp_execute_stage tspp_execute_stage_inst (
    .CLK        (CLK),
    .reset      (reset),
    .fetch_ex   (fetch_ex),
    .stall      (stall),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .rs1_sel    (rs1_sel),
    .rs2_sel    (rs2_sel),
    .rd_sel     (rd_sel),
    .rf_wen     (rf_wen),
    .rf_wdata   (rf_wdata),
    .dbus       (dbus),
    .brj_taken  (brj_taken),
    .brj_addr   (brj_addr),
    .mem_access (mem_access),
    .halt_seen  (halt_seen),
    .retire     (retire)
  );

  rv32i_reg_file rv32i_reg_file_inst (
    .CLK      (CLK),
    .reset    (reset),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rd_sel   (rd_sel),
    .wen      (rf_wen),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  data_ram data_ram_inst (
    .CLK   (CLK),
    .reset (reset),
    .dbus  (dbus),
    .rdata (dmem_rdata),
    .busy  (busy)
  );

  tspp_hazard_fsm tspp_hazard_fsm_inst (
    .CLK        (CLK),
    .reset      (reset),
    .mem_access (mem_access),
    .busy       (busy),
    .brj_taken  (brj_taken),
    .halt_seen  (halt_seen),
    .stall      (stall),
    .flush      (flush),
    .halt       (halt)
  );

endmodule

/* dv/tspp_assertions.sv */
module tspp_assertions (
  input logic CLK,
  input logic reset,
  input logic mem_access,
  input logic halt_seen,
  input logic stall,
  input logic flush,
  input logic halt
);

  // Count of failed assertions
  int assert_fails = 0;

  // Redirect and hold never overlap
  flush_stall_excl: assert property (@(posedge CLK) disable iff (reset) !(flush && stall))
    else begin
      $error("flush and stall high in the same cycle");
      assert_fails++;
    end

  // Halt is sticky
  halt_sticky: assert property (@(posedge CLK) disable iff (reset) halt |=> halt)
    else begin
      $error("halt dropped after being raised");
      assert_fails++;
    end

  // Stall only while an access or the halt word sits in execute, or once halted
  stall_cause: assert property (@(posedge CLK) disable iff (reset)
    stall |-> (mem_access || halt_seen || halt))
    else begin
      $error("stall raised with no memory access or halt");
      assert_fails++;
    end

endmodule

bind tspp_hazard_fsm tspp_assertions tspp_assertions_inst (
  .CLK        (CLK),
  .reset      (reset),
  .mem_access (mem_access),
  .halt_seen  (halt_seen),
  .stall      (stall),
  .flush      (flush),
  .halt       (halt)
);

/* dv/tspp_checker.sv */
module tspp_checker (
  input logic              CLK,
  input logic              reset,
  input tspp_pkg::retire_t retire
);

  // Expected retire list with one entry per E line
  tspp_pkg::word_t exp_pc[$];
  tspp_pkg::word_t exp_wdata[$];
  int              exp_rd[$];
  int              exp_mal[$];
  int              exp_test[$];
  // Test tags with their mismatch counts
  string           test_name[$];
  int              test_fails[$];
  int              retire_count = 0;
  int              tests_done = 0;
  int              fail_count = 0;

  task automatic load_expected();
    int              fd;
    string           line;
    string           tag;
    string           name;
    tspp_pkg::word_t pc;
    tspp_pkg::word_t wdata;
    int              rd;
    int              mal;
    fd = $fopen("dv/tspp_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/tspp_input.txt for the expected retires");
      fail_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      tag  = "";
      void'($fgets(line, fd));
      void'($sscanf(line, "%s", tag));
      if (tag == "T" && $sscanf(line, "%s %s", tag, name) == 2) begin
        test_name.push_back(name);
        test_fails.push_back(0);
      end else if (tag == "E"
                   && $sscanf(line, "%s %h %d %h %d", tag, pc, rd, wdata, mal) == 5) begin
        // Entries ahead of any tag still need a home
        if (test_name.size() == 0) begin
          test_name.push_back("untagged");
          test_fails.push_back(0);
        end
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_wdata.push_back(wdata);
        exp_mal.push_back(mal);
        exp_test.push_back(test_name.size() - 1);
      end
    end
    $fclose(fd);
  endtask

  task automatic compare(int t, int idx, string field, tspp_pkg::word_t expected,
                         tspp_pkg::word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s retire %0d %s: expected %h actual %h",
               test_name[t], idx, field, expected, actual);
      test_fails[t]++;
      fail_count++;
    end
  endtask

  task automatic check_retire();
    int idx;
    int t;
    idx = retire_count;
    retire_count++;
    if (idx >= exp_pc.size()) begin
      $display("extra retire at pc %h after the expected sequence ended", retire.pc);
      fail_count++;
      return;
    end
    t = exp_test[idx];
    compare(t, idx, "pc", exp_pc[idx], retire.pc);
    compare(t, idx, "rd", tspp_pkg::word_t'(exp_rd[idx]), {27'b0, retire.rd});
    compare(t, idx, "wdata", exp_wdata[idx], retire.wdata);
    compare(t, idx, "mal", tspp_pkg::word_t'(exp_mal[idx]), {31'b0, retire.mal});
    // Last entry of a tag closes that test
    if (idx == exp_pc.size() - 1 || exp_test[idx + 1] != t) begin
      if (test_fails[t] == 0) begin
        $display("test %s: ok", test_name[t]);
      end else begin
        $display("test %s: %0d mismatches", test_name[t], test_fails[t]);
      end
      tests_done++;
    end
  endtask

  task automatic final_report();
    if (retire_count < exp_pc.size()) begin
      $display("missing retires: only %0d of %0d expected instructions retired",
               retire_count, exp_pc.size());
      fail_count++;
    end
    $display("summary: %0d of %0d tests finished, %0d retires, %0d errors",
             tests_done, test_name.size(), retire_count, fail_count);
  endtask

  initial begin
    load_expected();
  end

  // Registered retire outputs are settled at the falling edge
  always @(negedge CLK) begin
    if (reset !== 1'b1 && retire.valid === 1'b1) begin
      check_retire();
    end
  end

endmodule

/* dv/tspp_tb.sv */
module tspp_tb;

  logic              CLK;
  logic              reset;
  tspp_pkg::word_t   imem_rdata;
  tspp_pkg::word_t   imem_addr;
  tspp_pkg::retire_t retire;
  logic              halt;

  // Program image keyed by byte address
  tspp_pkg::word_t imem_image [tspp_pkg::word_t];
  bit              image_ok;
  bit              halted;

  tspp_top tspp_top_inst (
    .CLK        (CLK),
    .reset      (reset),
    .imem_rdata (imem_rdata),
    .imem_addr  (imem_addr),
    .retire     (retire),
    .halt       (halt)
  );

  // Retire trace comparison lives here
  tspp_checker tspp_checker_inst (
    .CLK    (CLK),
    .reset  (reset),
    .retire (retire)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Unloaded or unknown addresses read as ADDI x0, x0, 0
  function automatic tspp_pkg::word_t fetch_word(tspp_pkg::word_t addr);
    if ($isunknown(addr) || !imem_image.exists(addr)) begin
      return 32'h0000_0013;
    end
    return imem_image[addr];
  endfunction

  // Only the I lines matter here
  task automatic load_image();
    int              fd;
    string           line;
    string           tag;
    tspp_pkg::word_t addr;
    tspp_pkg::word_t word;
    fd = $fopen("dv/tspp_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/tspp_input.txt for the program image");
      image_ok = 1'b0;
      return;
    end
    image_ok = 1'b1;
    while (!$feof(fd)) begin
      line = "";
      tag  = "";
      void'($fgets(line, fd));
      void'($sscanf(line, "%s", tag));
      if (tag == "I" && $sscanf(line, "%s %h %h", tag, addr, word) == 3) begin
        imem_image[addr] = word;
      end
    end
    $fclose(fd);
  endtask

  // Same-cycle instruction memory refreshed on the falling edge
  always @(negedge CLK) begin
    imem_rdata <= fetch_word(imem_addr);
  end

  task automatic wait_for_halt(input int max_cycles, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < max_cycles) begin
      @(negedge CLK);
      seen = (halt === 1'b1);
      cycles++;
    end
  endtask

  initial begin
    reset      = 1'b1;
    imem_rdata = 32'h0000_0013;
    load_image();
    // Sixteen reset cycles released on a falling edge
    repeat (16) @(negedge CLK);
    reset = 1'b0;
    wait_for_halt(2000, halted);
    if (halted) begin
      // Window for anything that retires after halt
      repeat (10) @(negedge CLK);
    end else begin
      $display("timeout: core never halted within 2000 cycles");
    end
    tspp_checker_inst.final_report();
    if (halted && image_ok && tspp_checker_inst.fail_count == 0
        && tspp_top_inst.tspp_hazard_fsm_inst.tspp_assertions_inst.assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* dv/tspp_input.txt */
# I <byte addr hex> <instr hex>   program image, T <name> opens a test
# E <pc hex> <rd dec> <wdata hex> <mal>   expected retire in order
T alu_imm
I 00000000 ff800093  addi x1, x0, -8
I 00000004 00300113  addi x2, x0, 3
I 00000008 123451b7  lui x3, 0x12345
I 0000000c 00001217  auipc x4, 0x1
I 00000010 4020d2b3  sra x5, x1, x2
I 00000014 00113333  sltu x6, x2, x1
I 00000018 402183b3  sub x7, x3, x2
I 0000001c 0020d433  srl x8, x1, x2
I 00000020 0020a4b3  slt x9, x1, x2
I 00000024 0ff1c513  xori x10, x3, 0xff
E 00000000 1 fffffff8 0
E 00000004 2 00000003 0
E 00000008 3 12345000 0
E 0000000c 4 0000100c 0
E 00000010 5 ffffffff 0
E 00000014 6 00000001 0
E 00000018 7 12344ffd 0
E 0000001c 8 1fffffff 0
E 00000020 9 00000001 0
E 00000024 10 123450ff 0
T branch_jump
I 00000028 00910463  beq x2, x9, +8
I 0000002c 00911463  bne x2, x9, +8
I 00000030 00100593  addi x11, x0, 1
I 00000034 0020c463  blt x1, x2, +8
I 00000038 00200593  addi x11, x0, 2
I 0000003c 0020e463  bltu x1, x2, +8
I 00000040 00c0066f  jal x12, +12
I 00000044 00300593  addi x11, x0, 3
I 00000048 00400593  addi x11, x0, 4
I 0000004c 06000693  addi x13, x0, 0x60
I 00000050 00568767  jalr x14, 5(x13)
E 00000028 0 00000000 0
E 0000002c 0 00000000 0
E 00000034 0 00000000 0
E 0000003c 0 00000000 0
E 00000040 12 00000044 0
E 0000004c 13 00000060 0
E 00000050 14 00000054 0
T byte_lanes
I 00000064 10000793  addi x15, x0, 0x100
I 00000068 0a100813  addi x16, x0, 0xa1
I 0000006c 01078023  sb x16, 0(x15)
I 00000070 0b200813  addi x16, x0, 0xb2
I 00000074 010780a3  sb x16, 1(x15)
I 00000078 0c300813  addi x16, x0, 0xc3
I 0000007c 01078123  sb x16, 2(x15)
I 00000080 0d400813  addi x16, x0, 0xd4
I 00000084 010781a3  sb x16, 3(x15)
I 00000088 0007a883  lw x17, 0(x15)
I 0000008c 00378903  lb x18, 3(x15)
I 00000090 0017c983  lbu x19, 1(x15)
I 00000094 00279a03  lh x20, 2(x15)
I 00000098 0007da83  lhu x21, 0(x15)
I 0000009c 01179223  sh x17, 4(x15)
I 000000a0 00a79323  sh x10, 6(x15)
I 000000a4 0047ab83  lw x23, 4(x15)
I 000000a8 00479c03  lh x24, 4(x15)
I 000000ac 0067dc83  lhu x25, 6(x15)
E 00000064 15 00000100 0
E 00000068 16 000000a1 0
E 0000006c 0 00000000 0
E 00000070 16 000000b2 0
E 00000074 0 00000000 0
E 00000078 16 000000c3 0
E 0000007c 0 00000000 0
E 00000080 16 000000d4 0
E 00000084 0 00000000 0
E 00000088 17 d4c3b2a1 0
E 0000008c 18 ffffffd4 0
E 00000090 19 000000b2 0
E 00000094 20 ffffd4c3 0
E 00000098 21 0000b2a1 0
E 0000009c 0 00000000 0
E 000000a0 0 00000000 0
E 000000a4 23 50ffb2a1 0
E 000000a8 24 ffffb2a1 0
E 000000ac 25 000050ff 0
T misaligned
I 000000b0 0017ad03  lw x26, 1(x15)
I 000000b4 011791a3  sh x17, 3(x15)
I 000000b8 0007ad83  lw x27, 0(x15)
I 000000bc 000d0e33  add x28, x26, x0
E 000000b0 0 00000000 1
E 000000b4 0 00000000 1
E 000000b8 27 d4c3b2a1 0
E 000000bc 28 00000000 0
T stall_halt
I 000000c0 0177a423  sw x23, 8(x15)
I 000000c4 0087ae83  lw x29, 8(x15)
I 000000c8 001e8f13  addi x30, x29, 1
I 000000cc ffffffff  halt
I 000000d0 00100f93  addi x31, x0, 1
E 000000c0 0 00000000 0
E 000000c4 29 50ffb2a1 0
E 000000c8 30 50ffb2a2 0

/* sources.f */
design/tspp_pkg.sv
design/tspp_fetch_stage.sv
design/tspp_execute_stage.sv
design/rv32i_reg_file.sv
design/tspp_hazard_fsm.sv
design/dmem_latency_timer.sv
design/data_ram.sv
design/tspp_top.sv
dv/tspp_assertions.sv
dv/tspp_checker.sv
dv/tspp_tb.sv

/* Bender.yml */
package:
  name: tspp

sources:
  - files:
      - design/tspp_pkg.sv
      - design/tspp_fetch_stage.sv
      - design/tspp_execute_stage.sv
      - design/rv32i_reg_file.sv
      - design/tspp_hazard_fsm.sv
      - design/dmem_latency_timer.sv
      - design/data_ram.sv
      - design/tspp_top.sv
  - target: simulation
    files:
      - dv/tspp_assertions.sv
      - dv/tspp_checker.sv
      - dv/tspp_tb.sv
